/* Bender.yml */
package:
  name: icache

sources:
  - files:
      - src/icache_pkg.sv
      - src/icache_tag_store.sv
      - src/icache_data_store.sv
      - src/icache_replace.sv
      - src/icache_ctrl.sv
      - src/icache_top.sv
  - target: test
    files:
      - verification/icache_assertions.sv
      - verification/icache_tb.sv

/* icache_top.f */
src/icache_pkg.sv
src/icache_tag_store.sv
src/icache_data_store.sv
src/icache_replace.sv
src/icache_ctrl.sv
src/icache_top.sv
verification/icache_assertions.sv
verification/icache_tb.sv

/* src/icache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl
        import icache_pkg::*;
#(
        parameter int NUM_SETS = 8,
        localparam int IDX_W = $clog2(NUM_SETS),
        localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W
)
(
        input  logic             clk,
        input  logic             rst,

        input  logic             cpu_req_valid,
        input  addr_t            cpu_req_addr,
        output logic             cpu_req_ready,

        output logic             rsp_valid,
        output word_t            rsp_data,
        input  logic             rsp_ready,

        output logic             mem_req_valid,
        output addr_t            mem_req_addr,
        input  logic             mem_req_ready,

        input  logic             mem_rsp_valid,
        input  mem_beat_t        mem_rsp,
        output logic             mem_rsp_ready,

        input  way_vec_t         hit_vec,
        input  line_t            lines [NUM_WAYS],
        input  way_idx_t         way_sel,
        output ctrl_state_e      state,
        output logic [IDX_W-1:0] index,
        output logic [TAG_W-1:0] tag,
        output way_vec_t         fill_we,
        output line_t            fill_line
);

        localparam int WSEL_W = $clog2(WORDS_PER_LINE);

        ctrl_state_e       next_state;
        addr_t             addr_q;
        line_t             line_buf;
        logic [WSEL_W-1:0] word_off;

        always_ff @(posedge clk)
        begin
                if (rst)
                        state <= WAIT;
                else
                        state <= next_state;
        end

        always_comb
        begin
                next_state = state;
                unique case (state)
                        WAIT:     if (cpu_req_valid) next_state = TAG_RD;
                        TAG_RD:   next_state = (|hit_vec) ? CACHE_RD : EVICT;
                        CACHE_RD: next_state = RESP;
                        EVICT:    next_state = MEM_RD;
                        MEM_RD:   if (mem_req_ready) next_state = RECV;
                        RECV:     if (mem_rsp_valid && mem_rsp.last) next_state = REFILL;
                        REFILL:   next_state = RESP;
                        RESP:     if (rsp_ready) next_state = WAIT;
                        default:  next_state = WAIT;
                endcase
        end

        always_ff @(posedge clk)
        begin
                if (cpu_req_valid && cpu_req_ready)
                        addr_q <= cpu_req_addr;
        end

        // Hit line loaded whole, miss line shifted in from the top
        always_ff @(posedge clk)
        begin
                if (state == CACHE_RD)
                        line_buf <= lines[way_sel];
                else if (mem_rsp_valid && mem_rsp_ready)
                        line_buf <= {mem_rsp.data, line_buf[LINE_W-1:WORD_W]};
        end

        assign index = addr_q[OFFSET_W +: IDX_W];
        assign tag   = addr_q[ADDR_W-1 -: TAG_W];

        assign cpu_req_ready = (state == WAIT);
        assign mem_req_valid = (state == MEM_RD);
        assign mem_rsp_ready = (state == RECV);
        assign rsp_valid     = (state == RESP);

        assign mem_req_addr = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

        assign fill_we   = (state == REFILL) ? way_vec_t'(1) << way_sel : '0;
        assign fill_line = line_buf;

        assign word_off = addr_q[2 +: WSEL_W];    // Offset bits 4:2
        assign rsp_data = line_buf[word_off*WORD_W +: WORD_W];

endmodule

`default_nettype wire

/* src/icache_data_store.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_data_store
        import icache_pkg::*;
#(
        parameter int NUM_SETS = 8,
        localparam int IDX_W = $clog2(NUM_SETS)
)
(
        input  logic             clk,
        input  logic [IDX_W-1:0] index,
        input  way_vec_t         fill_we,
        input  line_t            fill_line,
        output line_t            lines [NUM_WAYS]
);

        line_t data_mem [NUM_SETS][NUM_WAYS];

        always_ff @(posedge clk)
        begin
                for (int w = 0; w < NUM_WAYS; w++)
                begin
                        if (fill_we[w])
                                data_mem[index][w] <= fill_line;
                end
        end

        // All ways read at once, the controller picks one
        always_comb
        begin
                for (int w = 0; w < NUM_WAYS; w++)
                        lines[w] = data_mem[index][w];
        end

endmodule

`default_nettype wire

/* src/icache_pkg.sv */
`default_nettype none

package icache_pkg;

        localparam int ADDR_W         = 32;
        localparam int WORD_W         = 32;
        localparam int WORDS_PER_LINE = 8;
        localparam int OFFSET_W       = 5;        // Byte offset within a line
        localparam int NUM_WAYS       = 4;
        localparam int LINE_W         = WORDS_PER_LINE * WORD_W;

        typedef logic [ADDR_W-1:0] addr_t;
        typedef logic [WORD_W-1:0] word_t;
        typedef logic [LINE_W-1:0] line_t;       // Word 0 in the low bits

        typedef logic [NUM_WAYS-1:0] way_vec_t;
        typedef logic [$clog2(NUM_WAYS)-1:0] way_idx_t;

        // One beat of a memory burst
        typedef struct packed {
                word_t data;
                logic  last;
        } mem_beat_t;

        typedef enum logic [2:0] {
                WAIT,
                TAG_RD,
                CACHE_RD,
                EVICT,                            // Victim chosen, LRU updated
                MEM_RD,
                RECV,
                REFILL,                           // Line written to the victim way
                RESP
        } ctrl_state_e;

endpackage

`default_nettype wire

/* src/icache_replace.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_replace
        import icache_pkg::*;
#(
        parameter int NUM_SETS = 8,
        localparam int IDX_W = $clog2(NUM_SETS)
)
(
        input  logic             clk,
        input  logic             rst,
        input  ctrl_state_e      state,
        input  logic [IDX_W-1:0] index,
        input  way_vec_t         hit_vec,
        output way_idx_t         way_sel
);

        // Row w set means way w used after the ways whose bits are set
        way_vec_t lru [NUM_SETS][NUM_WAYS];

        way_idx_t hit_way;
        way_idx_t victim;

        always_comb
        begin
                hit_way = '0;
                for (int w = NUM_WAYS - 1; w >= 0; w--)
                begin
                        if (hit_vec[w])
                                hit_way = way_idx_t'(w);
                end
        end

        // Lowest way with an all-zero row is least recently used
        always_comb
        begin
                victim = '0;
                for (int w = NUM_WAYS - 1; w >= 0; w--)
                begin
                        if (lru[index][w] == '0)
                                victim = way_idx_t'(w);
                end
        end

        always_ff @(posedge clk)
        begin
                if (rst)
                        way_sel <= '0;
                else if (state == TAG_RD)
                        way_sel <= (|hit_vec) ? hit_way : victim;
        end

        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        for (int s = 0; s < NUM_SETS; s++)
                                for (int w = 0; w < NUM_WAYS; w++)
                                        lru[s][w] <= '0;
                end
                else if (state == CACHE_RD || state == EVICT)
                begin
                        lru[index][way_sel] <= '1;           // Row set
                        for (int w = 0; w < NUM_WAYS; w++)
                                lru[index][w][way_sel] <= 1'b0;  // Column cleared, wins on diagonal
                end
        end

endmodule

`default_nettype wire

/* src/icache_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tag_store
        import icache_pkg::*;
#(
        parameter int NUM_SETS = 8,
        localparam int IDX_W = $clog2(NUM_SETS),
        localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W
)
(
        input  logic             clk,
        input  logic             rst,
        input  logic [IDX_W-1:0] index,
        input  logic [TAG_W-1:0] tag,
        input  way_vec_t         fill_we,
        output way_vec_t         hit_vec
);

        logic [TAG_W-1:0] tag_mem [NUM_SETS][NUM_WAYS];
        way_vec_t         valid_mem [NUM_SETS];

        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        for (int s = 0; s < NUM_SETS; s++)
                                valid_mem[s] <= '0;
                end
                else
                begin
                        valid_mem[index] <= valid_mem[index] | fill_we;
                end
        end

        always_ff @(posedge clk)
        begin
                for (int w = 0; w < NUM_WAYS; w++)
                begin
                        if (fill_we[w])
                                tag_mem[index][w] <= tag;
                end
        end

        // Tag compare across all ways
        always_comb
        begin
                for (int w = 0; w < NUM_WAYS; w++)
                        hit_vec[w] = valid_mem[index][w] && (tag_mem[index][w] == tag);
        end

endmodule

`default_nettype wire

/* src/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top
        import icache_pkg::*;
#(
        parameter int NUM_SETS = 8
)
(
        input  logic      clk,
        input  logic      rst,

        input  logic      cpu_req_valid,
        input  addr_t     cpu_req_addr,
        output logic      cpu_req_ready,

        output logic      rsp_valid,
        output word_t     rsp_data,
        input  logic      rsp_ready,

        output logic      mem_req_valid,
        output addr_t     mem_req_addr,
        input  logic      mem_req_ready,

        input  logic      mem_rsp_valid,
        input  mem_beat_t mem_rsp,
        output logic      mem_rsp_ready
);

        localparam int IDX_W = $clog2(NUM_SETS);
        localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W;

        ctrl_state_e      state;
        logic [IDX_W-1:0] index;
        logic [TAG_W-1:0] tag;
        way_vec_t         hit_vec;
        way_vec_t         fill_we;
        way_idx_t         way_sel;
        line_t            fill_line;
        line_t            lines [NUM_WAYS];

        icache_ctrl #(.NUM_SETS(NUM_SETS)) i_ctrl (
                .clk           (clk),
                .rst           (rst),
                .cpu_req_valid (cpu_req_valid),
                .cpu_req_addr  (cpu_req_addr),
                .cpu_req_ready (cpu_req_ready),
                .rsp_valid     (rsp_valid),
                .rsp_data      (rsp_data),
                .rsp_ready     (rsp_ready),
                .mem_req_valid (mem_req_valid),
                .mem_req_addr  (mem_req_addr),
                .mem_req_ready (mem_req_ready),
                .mem_rsp_valid (mem_rsp_valid),
                .mem_rsp       (mem_rsp),
                .mem_rsp_ready (mem_rsp_ready),
                .hit_vec       (hit_vec),
                .lines         (lines),
                .way_sel       (way_sel),
                .state         (state),
                .index         (index),
                .tag           (tag),
                .fill_we       (fill_we),
                .fill_line     (fill_line)
        );

        icache_tag_store #(.NUM_SETS(NUM_SETS)) i_tag_store (
                .clk     (clk),
                .rst     (rst),
                .index   (index),
                .tag     (tag),
                .fill_we (fill_we),
                .hit_vec (hit_vec)
        );

        icache_data_store #(.NUM_SETS(NUM_SETS)) i_data_store (
                .clk       (clk),
                .index     (index),
                .fill_we   (fill_we),
                .fill_line (fill_line),
                .lines     (lines)
        );

        icache_replace #(.NUM_SETS(NUM_SETS)) i_replace (
                .clk     (clk),
                .rst     (rst),
                .state   (state),
                .index   (index),
                .hit_vec (hit_vec),
                .way_sel (way_sel)
        );

endmodule

`default_nettype wire

/* verification/icache_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_assertions
        import icache_pkg::*;
(
        input  logic  clk,
        input  logic  rst,
        input  logic  cpu_req_ready,
        input  logic  rsp_valid,
        input  word_t rsp_data,
        input  logic  rsp_ready,
        input  logic  mem_req_valid,
        input  addr_t mem_req_addr,
        input  logic  mem_req_ready,
        input  logic  mem_rsp_ready
);

        // Response held until taken
        rsp_hold: assert property (@(posedge clk) disable iff (rst)
                rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
                else $error("rsp_valid dropped before transfer");

        mem_req_hold: assert property (@(posedge clk) disable iff (rst)
                mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr))
                else $error("mem_req_valid dropped before transfer");

        no_accept_during_rsp: assert property (@(posedge clk) disable iff (rst)
                !(cpu_req_ready && rsp_valid))
                else $error("cpu_req_ready high with rsp_valid");

        no_beats_during_req: assert property (@(posedge clk) disable iff (rst)
                !(mem_rsp_ready && mem_req_valid))
                else $error("mem_rsp_ready high with mem_req_valid");

endmodule

bind icache_top icache_assertions i_assertions (.*);

`default_nettype wire

/* verification/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tb
        import icache_pkg::*;
;

        localparam int  NUM_FETCHES = 40;
        localparam int  FETCH_MAX   = 300;      // Cycles per fetch with stalls
        localparam int  MAX_CYCLES  = 16 + NUM_FETCHES * FETCH_MAX;
        localparam word_t DATA_KEY  = 32'h5a5a_c3c3;

        logic      clk;
        logic      rst;
        logic      cpu_req_valid;
        addr_t     cpu_req_addr;
        logic      cpu_req_ready;
        logic      rsp_valid;
        word_t     rsp_data;
        logic      rsp_ready;
        logic      mem_req_valid;
        addr_t     mem_req_addr;
        logic      mem_req_ready;
        logic      mem_rsp_valid;
        mem_beat_t mem_rsp;
        logic      mem_rsp_ready;

        int        errors;
        int        tests_run;
        int        tests_failed;
        int        test_start_errors;
        int        cycle_count;
        int        mem_req_count;
        bit        random_stalls;
        addr_t     burst_addr;
        int        beat_cnt;
        bit        bursting;

        icache_top i_icache_top (.*);

        initial
        begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        function automatic word_t model_word(addr_t a);
                return a ^ DATA_KEY;
        endfunction

        // Memory model with optional random stalls
        always @(posedge clk)
        begin
                int  nb;
                bit  fire;
                fire = mem_rsp_valid && mem_rsp_ready;
                nb   = fire ? beat_cnt + 1 : beat_cnt;
                if (rst)
                begin
                        mem_req_ready <= 1'b0;
                        mem_rsp_valid <= 1'b0;
                        bursting      <= 1'b0;
                end
                else
                begin
                        mem_req_ready <= random_stalls ? 1'($urandom % 2) : 1'b1;
                        if (mem_req_valid && mem_req_ready)
                        begin
                                burst_addr <= mem_req_addr;
                                beat_cnt   <= 0;
                                bursting   <= 1'b1;
                                mem_req_count++;
                        end
                        if (bursting)
                        begin
                                beat_cnt <= nb;
                                if (fire && mem_rsp.last)
                                        bursting <= 1'b0;
                                if (!fire && mem_rsp_valid)
                                        mem_rsp_valid <= 1'b1;   // Hold until taken
                                else if (nb < WORDS_PER_LINE)
                                begin
                                        mem_rsp_valid <= random_stalls ? 1'($urandom % 2) : 1'b1;
                                        mem_rsp.data  <= model_word(burst_addr + addr_t'(nb * 4));
                                        mem_rsp.last  <= (nb == WORDS_PER_LINE - 1);
                                end
                                else
                                        mem_rsp_valid <= 1'b0;
                        end
                end
        end

        always @(posedge clk)
        begin
                cycle_count++;
                if (cycle_count > MAX_CYCLES)
                begin
                        $display("Timeout after %0d cycles, DUT stopped responding", cycle_count);
                        $display("tests failed");
                        $finish;
                end
        end

        task automatic check_word(string name, word_t got, word_t exp);
                if (got !== exp)
                begin
                        $display("Fail %s: got %h expected %h", name, got, exp);
                        errors++;
                end
        endtask

        task automatic check_addr(string name, addr_t got, addr_t exp);
                if (got !== exp)
                begin
                        $display("Fail %s: got %h expected %h", name, got, exp);
                        errors++;
                end
        endtask

        task automatic check_flag(string name, logic got, logic exp);
                if (got !== exp)
                begin
                        $display("Fail %s: got %h expected %h", name, got, exp);
                        errors++;
                end
        endtask

        task automatic start_test();
                test_start_errors = errors;
        endtask

        task automatic finish_test(string name);
                tests_run++;
                if (errors != test_start_errors)
                begin
                        tests_failed++;
                        $display("%s: FAILED (%0d errors)", name, errors - test_start_errors);
                end
                else
                        $display("%s: ok", name);
        endtask

        // One fetch, returns data, latency to rsp_valid and new memory requests
        task automatic fetch(input addr_t addr, output word_t data, output int latency,
                             output int reqs);
                int reqs0;
                int cyc;
                cyc     = 0;
                latency = 0;
                @(posedge clk);
                cpu_req_valid <= 1'b1;
                cpu_req_addr  <= addr;
                do
                        @(posedge clk);
                while (!(cpu_req_valid && cpu_req_ready));
                cpu_req_valid <= 1'b0;
                rsp_ready     <= random_stalls ? 1'($urandom % 2) : 1'b1;
                reqs0 = mem_req_count;
                forever
                begin
                        @(posedge clk);
                        cyc++;
                        if (rsp_valid && latency == 0)
                                latency = cyc;
                        if (rsp_valid && rsp_ready)
                                break;
                        rsp_ready <= random_stalls ? 1'($urandom % 2) : 1'b1;
                end
                data = rsp_data;
                rsp_ready <= 1'b0;
                @(posedge clk);
                check_flag("rsp_valid", rsp_valid, 1'b0);
                reqs = mem_req_count - reqs0;
        endtask

        task automatic fetch_expect(addr_t addr, int exp_reqs);
                word_t data;
                int    lat;
                int    reqs;
                fetch(addr, data, lat, reqs);
                check_word("rsp_data", data, model_word(addr));
                check_word("mem_req_count", word_t'(reqs), word_t'(exp_reqs));
                if (exp_reqs == 0 && !random_stalls)
                        check_word("hit_latency", word_t'(lat), 3);
        endtask

        task automatic test_reset_state();
                start_test();
                check_flag("cpu_req_ready", cpu_req_ready, 1'b1);
                check_flag("rsp_valid", rsp_valid, 1'b0);
                check_flag("mem_req_valid", mem_req_valid, 1'b0);
                check_flag("mem_rsp_ready", mem_rsp_ready, 1'b0);
                finish_test("reset state");
        endtask

        task automatic test_cold_miss();
                start_test();
                fetch_expect(32'h1000_0044, 1);
                check_addr("mem_req_addr", burst_addr, 32'h1000_0040);
                finish_test("cold miss");
        endtask

        task automatic test_line_hits();
                start_test();
                for (int w = 0; w < WORDS_PER_LINE; w++)
                        fetch_expect(32'h1000_0040 + addr_t'(w * 4), 0);
                finish_test("line hits");
        endtask

        task automatic test_lru();
                addr_t base;
                start_test();
                base = 32'h2000_00a0;     // Set 5
                for (int k = 0; k < 4; k++)
                        fetch_expect(base + addr_t'(k * 'h100 + k * 4), 1);
                fetch_expect(base, 0);
                fetch_expect(base + 32'h400, 1);        // Evicts the second line
                fetch_expect(base + 32'h8, 0);
                fetch_expect(base + 32'h100, 1);
                finish_test("lru replacement");
        endtask

        task automatic test_random_stalls();
                word_t data;
                int    lat;
                int    reqs;
                addr_t a;
                start_test();
                random_stalls = 1'b1;
                for (int i = 0; i < 16; i++)
                begin
                        a = {20'h30000 + 20'($urandom % 4), 7'($urandom), 5'($urandom) & 5'h1c};
                        fetch(a, data, lat, reqs);
                        check_word("rsp_data", data, model_word(a));
                end
                random_stalls = 1'b0;
                finish_test("random stalls");
        endtask

        initial
        begin
                void'($urandom(8));
                errors        = 0;
                tests_run     = 0;
                tests_failed  = 0;
                cycle_count   = 0;
                mem_req_count = 0;
                random_stalls = 1'b0;
                rst           = 1'b1;
                cpu_req_valid = 1'b0;
                cpu_req_addr  = '0;
                rsp_ready     = 1'b0;
                mem_req_ready = 1'b0;
                mem_rsp_valid = 1'b0;
                mem_rsp       = '0;
                repeat (16) @(posedge clk);
                rst <= 1'b0;
                @(posedge clk);
                test_reset_state();
                test_cold_miss();
                test_line_hits();
                test_lru();
                test_random_stalls();
                $display("%0d tests run, %0d failed, %0d check errors",
                         tests_run, tests_failed, errors);
                if (errors == 0)
                        $display("all tests passed");
                else
                        $display("tests failed");
                $finish;
        end

endmodule

`default_nettype wire
